// ==== fifo_geom_pkg.sv ====
// FIFO geometry shared by the controllers, the storage array and the testbench
`default_nettype none

package fifo_geom_pkg;

  //--------------------------------------------------------------------------
  // Storage geometry
  //--------------------------------------------------------------------------

  // Number of entries held in the RAM
  localparam int fifo_depth = 8;

  // Width of one entry in bits
  localparam int data_width = 16;

  //--------------------------------------------------------------------------
  // Derived widths
  //--------------------------------------------------------------------------

  // Enough bits to index every entry of the RAM
  localparam int addr_width = $clog2(fifo_depth);

  // One bit wider than the address when the depth is a power of two,
  // so that a full FIFO can still report fifo_depth items or slots
  localparam int count_width = $clog2(fifo_depth + 1);

endpackage : fifo_geom_pkg

`default_nettype wire

// ==== credit_pkg.sv ====
// Push-side credit sizing, used by the push controller, the top level and the testbench
`default_nettype none

package credit_pkg;

  //--------------------------------------------------------------------------
  // Credit counter
  //--------------------------------------------------------------------------

  // The counter has to reach the full depth, since every entry is one credit
  localparam int credit_width = $clog2(fifo_geom_pkg::fifo_depth + 1);

  // Credits held back for the sender when reset is released
  // Each free entry is worth exactly one credit
  localparam int init_credits = fifo_geom_pkg::fifo_depth;

endpackage : credit_pkg

`default_nettype wire

// ==== fifo_ram_1r1w.sv ====
// Flop-based 1R1W storage for the FIFO, one-cycle write and combinational read
`default_nettype none

module fifo_ram_1r1w (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 wr_valid,
  input  logic [fifo_geom_pkg::addr_width-1:0] wr_addr,
  input  logic [fifo_geom_pkg::data_width-1:0] wr_data,
  input  logic [fifo_geom_pkg::addr_width-1:0] rd_addr,
  output logic [fifo_geom_pkg::data_width-1:0] rd_data
);

  import fifo_geom_pkg::*;

  // One word per FIFO entry
  logic [data_width-1:0] mem [fifo_depth];

  // The write lands on the edge, so a read of the same address in the
  // same cycle still returns the old word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < fifo_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Zero-latency read port
  assign rd_data = mem[rd_addr];

endmodule : fifo_ram_1r1w

`default_nettype wire

// ==== fifo_push_ctrl_credit.sv ====
// Push-side control of the credit FIFO: grants credits, routes pushes to bypass or RAM
`default_nettype none

module fifo_push_ctrl_credit #(
  // When set, a push may be handed straight to the pop side
  parameter bit enable_bypass = 1'b1
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // Credit/valid push interface
  input  logic                                  push_credit_stall,
  output logic                                  push_credit,
  input  logic                                  push_valid,
  input  logic [fifo_geom_pkg::data_width-1:0]  push_data,

  // Push-side status
  output logic                                  full,
  output logic [fifo_geom_pkg::count_width-1:0] slots,
  output logic [credit_pkg::credit_width-1:0]   push_credit_count,

  // Bypass path towards the pop controller
  input  logic                                  bypass_ready,
  output logic                                  bypass_valid,
  output logic [fifo_geom_pkg::data_width-1:0]  bypass_data,

  // RAM write port
  output logic                                  ram_wr_valid,
  output logic [fifo_geom_pkg::addr_width-1:0]  ram_wr_addr,
  output logic [fifo_geom_pkg::data_width-1:0]  ram_wr_data,

  // Occupancy pulses shared with the pop controller
  output logic                                  ram_push,
  input  logic                                  ram_pop
);

  import fifo_geom_pkg::*;
  import credit_pkg::*;

  logic                    credit_en;
  logic                    bypass_push;
  logic                    credit_return;
  logic [credit_width-1:0] credit_count_next;
  logic [addr_width-1:0]   wr_ptr;
  logic [count_width-1:0]  slots_next;

  //--------------------------------------------------------------------------
  // Credit issue
  //--------------------------------------------------------------------------

  // Goes high on the first edge after reset is released
  // Credit issue starts from that cycle on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_en <= 1'b0;
    end else begin
      credit_en <= 1'b1;
    end
  end

  // One credit per cycle while any are left and the sender is not stalling
  // The stall acts in the same cycle, so a credit never coincides with it
  assign push_credit = credit_en && !push_credit_stall && (push_credit_count != '0);

  // Every entry leaving the FIFO hands a credit back
  // This holds for RAM pops and for words that went through the bypass
  assign credit_return = ram_pop || bypass_push;

  // A grant and a return in the same cycle cancel out
  always_comb begin
    credit_count_next = push_credit_count;
    if (push_credit && !credit_return) begin
      credit_count_next = push_credit_count - credit_width'(1);
    end else if (!push_credit && credit_return) begin
      credit_count_next = push_credit_count + credit_width'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_credit_count <= credit_width'(init_credits);
    end else begin
      push_credit_count <= credit_count_next;
    end
  end

  //--------------------------------------------------------------------------
  // Push steering
  //--------------------------------------------------------------------------

  // The bypass is offered every push, and the pop side decides whether
  // it can take the word this cycle
  assign bypass_valid = enable_bypass && push_valid;
  assign bypass_data  = push_data;
  assign bypass_push  = bypass_valid && bypass_ready;

  // Pushes not consumed by the bypass land in the RAM at the write pointer
  assign ram_push     = push_valid && !bypass_push;
  assign ram_wr_valid = ram_push;
  assign ram_wr_addr  = wr_ptr;
  assign ram_wr_data  = push_data;

  // The write pointer wraps at the last entry, which also covers
  // depths that are not a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (ram_push) begin
      if (wr_ptr == addr_width'(fifo_depth - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + addr_width'(1);
      end
    end
  end

  //--------------------------------------------------------------------------
  // Slot tracking
  //--------------------------------------------------------------------------

  // Slots follow the RAM contents only; bypassed words never take a slot
  always_comb begin
    slots_next = slots;
    if (ram_push && !ram_pop) begin
      slots_next = slots - count_width'(1);
    end else if (!ram_push && ram_pop) begin
      slots_next = slots + count_width'(1);
    end
  end

  // Both flags are registered and move on the edge after the push or pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slots <= count_width'(fifo_depth);
      full  <= 1'b0;
    end else begin
      slots <= slots_next;
      full  <= (slots_next == '0);
    end
  end

endmodule : fifo_push_ctrl_credit

`default_nettype wire

// ==== fifo_pop_ctrl.sv ====
// Pop-side control of the credit FIFO: presents the head entry and tracks RAM occupancy
`default_nettype none

module fifo_pop_ctrl #(
  // When set, an empty FIFO forwards the push side straight to the output
  parameter bit enable_bypass = 1'b1
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // Ready/valid pop interface
  input  logic                                  pop_ready,
  output logic                                  pop_valid,
  output logic [fifo_geom_pkg::data_width-1:0]  pop_data,

  // Pop-side status
  output logic                                  empty,
  output logic [fifo_geom_pkg::count_width-1:0] items,

  // Bypass path from the push controller
  output logic                                  bypass_ready,
  input  logic                                  bypass_valid,
  input  logic [fifo_geom_pkg::data_width-1:0]  bypass_data,

  // RAM read port, data comes back in the same cycle
  output logic [fifo_geom_pkg::addr_width-1:0]  ram_rd_addr,
  input  logic [fifo_geom_pkg::data_width-1:0]  ram_rd_data,

  // Occupancy pulses shared with the push controller
  input  logic                                  ram_push,
  output logic                                  ram_pop
);

  import fifo_geom_pkg::*;

  logic                   ram_has_item;
  logic [addr_width-1:0]  rd_ptr;
  logic [count_width-1:0] items_next;

  //--------------------------------------------------------------------------
  // Head selection
  //--------------------------------------------------------------------------

  // The RAM always wins once it holds something, which keeps the order
  // intact when pushes arrive behind older entries
  assign ram_has_item = (items != '0);

  // Bypass is only offered while the RAM is drained and the receiver is
  // ready now; otherwise the push has to be stored
  assign bypass_ready = enable_bypass && !ram_has_item && pop_ready;

  // The read port is combinational, so the head word is visible as soon
  // as the item count says it has been written
  assign ram_rd_addr = rd_ptr;

  always_comb begin
    if (ram_has_item) begin
      pop_valid = 1'b1;
      pop_data  = ram_rd_data;
    end else begin
      pop_valid = enable_bypass && bypass_valid;
      pop_data  = bypass_data;
    end
  end

  // A transfer from RAM, bypass transfers are accounted on the push side
  assign ram_pop = ram_has_item && pop_ready;

  //--------------------------------------------------------------------------
  // Read pointer
  //--------------------------------------------------------------------------

  // Mirrors the write pointer: steps once per RAM pop and wraps at the end
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (ram_pop) begin
      if (rd_ptr == addr_width'(fifo_depth - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + addr_width'(1);
      end
    end
  end

  //--------------------------------------------------------------------------
  // Item tracking
  //--------------------------------------------------------------------------

  // Counts words sitting in RAM; a push and a pop together leave it unchanged
  always_comb begin
    items_next = items;
    if (ram_push && !ram_pop) begin
      items_next = items + count_width'(1);
    end else if (!ram_push && ram_pop) begin
      items_next = items - count_width'(1);
    end
  end

  // Registered status, updated on the edge after the push or pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items <= '0;
      empty <= 1'b1;
    end else begin
      items <= items_next;
      empty <= (items_next == '0);
    end
  end

endmodule : fifo_pop_ctrl

`default_nettype wire

// ==== fifo_push_credit_1r1w.sv ====
// Credit/valid push, ready/valid pop FIFO top level wiring both controllers to the RAM
`default_nettype none

module fifo_push_credit_1r1w #(
  // Zero-latency push-to-pop path when the FIFO is empty
  parameter bit enable_bypass = 1'b1
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // Push side
  input  logic                                  push_credit_stall,
  output logic                                  push_credit,
  input  logic                                  push_valid,
  input  logic [fifo_geom_pkg::data_width-1:0]  push_data,

  // Pop side
  input  logic                                  pop_ready,
  output logic                                  pop_valid,
  output logic [fifo_geom_pkg::data_width-1:0]  pop_data,

  // Status
  output logic                                  full,
  output logic                                  empty,
  output logic [fifo_geom_pkg::count_width-1:0] slots,
  output logic [fifo_geom_pkg::count_width-1:0] items,
  output logic [credit_pkg::credit_width-1:0]   push_credit_count
);

  import fifo_geom_pkg::*;

  //--------------------------------------------------------------------------
  // Internal nets
  //--------------------------------------------------------------------------

  // Bypass handshake between the two controllers
  logic                  bypass_ready;
  logic                  bypass_valid;
  logic [data_width-1:0] bypass_data;

  // Occupancy pulses, one per word entering or leaving the RAM
  logic                  ram_push;
  logic                  ram_pop;

  // RAM ports
  logic                  ram_wr_valid;
  logic [addr_width-1:0] ram_wr_addr;
  logic [data_width-1:0] ram_wr_data;
  logic [addr_width-1:0] ram_rd_addr;
  logic [data_width-1:0] ram_rd_data;

  //--------------------------------------------------------------------------
  // Instances
  //--------------------------------------------------------------------------

  fifo_push_ctrl_credit #(
    .enable_bypass(enable_bypass)
  ) fifo_push_ctrl_credit_inst (
    .clk, .rst_n,
    .push_credit_stall, .push_credit, .push_valid, .push_data,
    .full, .slots, .push_credit_count,
    .bypass_ready, .bypass_valid, .bypass_data,
    .ram_wr_valid, .ram_wr_addr, .ram_wr_data,
    .ram_push, .ram_pop
  );

  fifo_pop_ctrl #(
    .enable_bypass(enable_bypass)
  ) fifo_pop_ctrl_inst (
    .clk, .rst_n,
    .pop_ready, .pop_valid, .pop_data,
    .empty, .items,
    .bypass_ready, .bypass_valid, .bypass_data,
    .ram_rd_addr, .ram_rd_data,
    .ram_push, .ram_pop
  );

  // Write port is owned by the push side, read port by the pop side
  fifo_ram_1r1w fifo_ram_1r1w_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (ram_wr_valid),
    .wr_addr  (ram_wr_addr),
    .wr_data  (ram_wr_data),
    .rd_addr  (ram_rd_addr),
    .rd_data  (ram_rd_data)
  );

endmodule : fifo_push_credit_1r1w

`default_nettype wire

// ==== tb_fifo_push_credit_1r1w.sv ====
// Self-checking testbench for the credit FIFO, run as the simulation top through all.f
`default_nettype none

module tb_fifo_push_credit_1r1w;

  timeunit 1ns;
  timeprecision 1ps;

  import fifo_geom_pkg::*;
  import credit_pkg::*;

  // Longest any single wait may take, in clock cycles
  localparam int wait_limit = 2000;

  // Drive modes for pop_ready and push_credit_stall
  localparam int mode_low    = 0;
  localparam int mode_high   = 1;
  localparam int mode_random = 2;

  logic                   clk               = 1'b0;
  logic                   rst_n             = 1'b0;
  logic                   push_credit_stall = 1'b0;
  logic                   push_valid        = 1'b0;
  logic [data_width-1:0]  push_data         = '0;
  logic                   pop_ready         = 1'b0;
  logic                   push_credit;
  logic                   pop_valid;
  logic [data_width-1:0]  pop_data;
  logic                   full;
  logic                   empty;
  logic [count_width-1:0] slots;
  logic [count_width-1:0] items;
  logic [credit_width-1:0] push_credit_count;

  // Phase control is written on the falling edge and read on the rising edge
  int          ready_mode   = mode_low;
  int          stall_mode   = mode_low;
  bit          push_enable  = 1'b0;
  logic [31:0] rng_state    = 32'd36;

  // Reference model state
  logic [data_width-1:0] model_q [$];
  logic [data_width-1:0] model_head     = '0;
  int                    model_count    = 0;
  int                    credits_rcvd   = 0;
  int                    sender_credits = 0;
  int                    pushes_done    = 0;
  int                    pops_done      = 0;
  int                    outstanding;
  bit                    live           = 1'b0;
  int                    error_count    = 0;
  int                    timeout_count  = 0;

  // Credits handed out and not yet returned by a pop
  assign outstanding = credits_rcvd - pops_done;

  fifo_push_credit_1r1w #(
    .enable_bypass(1'b1)
  ) fifo_push_credit_1r1w_inst (
    .clk, .rst_n,
    .push_credit_stall, .push_credit, .push_valid, .push_data,
    .pop_ready, .pop_valid, .pop_data,
    .full, .empty, .slots, .items, .push_credit_count
  );

  always #50 clk = ~clk;

  //--------------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_mismatch(input string test_name, input int expected, input int actual);
    error_count++;
    $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
  endtask

  // Falling-edge polling keeps the model counters settled when they are read
  task automatic wait_for_occupancy(input int target, input string what);
    for (int n = 0; n < wait_limit; n++) begin
      if (model_count == target) begin
        return;
      end
      @(negedge clk);
    end
    timeout_count++;
    $display("Timed out after %0d cycles waiting for %s", wait_limit, what);
  endtask

  task automatic wait_for_credits(input int target);
    for (int n = 0; n < wait_limit; n++) begin
      if (credits_rcvd >= target) begin
        return;
      end
      @(negedge clk);
    end
    timeout_count++;
    $display("Timed out after %0d cycles waiting for %0d credits", wait_limit, target);
  endtask

  task automatic run_cycles(input int count);
    repeat (count) @(negedge clk);
  endtask

  //--------------------------------------------------------------------------
  // Sender and receiver
  //--------------------------------------------------------------------------

  // The sender pushes only while it holds a credit it has not spent yet
  // A push is charged against the credits when it is issued
  always @(posedge clk) begin
    logic [31:0] r;
    int          held;
    if (!rst_n) begin
      push_valid        <= 1'b0;
      pop_ready         <= 1'b0;
      push_credit_stall <= 1'b0;
    end else begin
      held = sender_credits + (push_credit ? 1 : 0);
      rng_state = xorshift32(rng_state);
      r = rng_state;
      if (push_enable && held > 0 && r[1:0] != 2'd0) begin
        push_valid <= 1'b1;
        push_data  <= r[31:32-data_width];
        held       = held - 1;
      end else begin
        push_valid <= 1'b0;
      end
      sender_credits <= held;
      // Ready leans towards high so the FIFO drains in random phases
      pop_ready         <= (ready_mode == mode_high) ||
                           (ready_mode == mode_random && r[4:2] != 3'd0);
      push_credit_stall <= (stall_mode == mode_high) ||
                           (stall_mode == mode_random && r[6:5] == 2'd0);
    end
  end

  //--------------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------------

  // Words in the queue mirror the RAM; a pop from an empty queue is a bypass
  always @(posedge clk) begin
    bit bypassed;
    bypassed = 1'b0;
    if (rst_n) begin
      live <= 1'b1;
      if (push_credit) begin
        credits_rcvd <= credits_rcvd + 1;
      end
      if (pop_valid && pop_ready) begin
        pops_done <= pops_done + 1;
        if (model_q.size() != 0) begin
          void'(model_q.pop_front());
        end else begin
          bypassed = 1'b1;
        end
      end
      if (push_valid) begin
        pushes_done <= pushes_done + 1;
        if (!bypassed) begin
          model_q.push_back(push_data);
        end
      end
      model_count <= model_q.size();
      model_head  <= (model_q.size() != 0) ? model_q[0] : '0;
    end
  end

  //--------------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------------

  // Credit issue
  a_reset_credit: assert property (@(posedge clk) !rst_n |-> !push_credit)
    else report_mismatch("reset_credit", 0, int'($sampled(push_credit)));
  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
      push_credit_stall |-> !push_credit)
    else report_mismatch("stall", 0, int'($sampled(push_credit)));
  a_grant: assert property (@(posedge clk) disable iff (!rst_n)
      live && !push_credit_stall && outstanding < fifo_depth |-> push_credit)
    else report_mismatch("credit_grant", 1, int'($sampled(push_credit)));
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
      outstanding <= fifo_depth)
    else report_mismatch("credit_bound", fifo_depth, $sampled(outstanding));
  a_credit_count: assert property (@(posedge clk) disable iff (!rst_n)
      int'(push_credit_count) == fifo_depth - outstanding)
    else report_mismatch("credit_count", fifo_depth - $sampled(outstanding),
                         int'($sampled(push_credit_count)));

  // Order, data and bypass
  a_order: assert property (@(posedge clk) disable iff (!rst_n)
      pop_valid && pop_ready && model_count != 0 |-> pop_data == model_head)
    else report_mismatch("order", int'($sampled(model_head)), int'($sampled(pop_data)));
  a_head_valid: assert property (@(posedge clk) disable iff (!rst_n)
      model_count != 0 |-> pop_valid)
    else report_mismatch("head_valid", 1, int'($sampled(pop_valid)));
  a_no_phantom: assert property (@(posedge clk) disable iff (!rst_n)
      model_count == 0 && !push_valid |-> !pop_valid)
    else report_mismatch("no_phantom", 0, int'($sampled(pop_valid)));
  a_bypass_valid: assert property (@(posedge clk) disable iff (!rst_n)
      push_valid && pop_ready && model_count == 0 |-> pop_valid)
    else report_mismatch("bypass_valid", 1, int'($sampled(pop_valid)));
  a_bypass_data: assert property (@(posedge clk) disable iff (!rst_n)
      push_valid && pop_ready && model_count == 0 |-> pop_data == push_data)
    else report_mismatch("bypass_data", int'($sampled(push_data)),
                         int'($sampled(pop_data)));

  // Status, which counts RAM contents only
  a_items: assert property (@(posedge clk) disable iff (!rst_n)
      int'(items) == model_count)
    else report_mismatch("items", $sampled(model_count), int'($sampled(items)));
  a_slots: assert property (@(posedge clk) disable iff (!rst_n)
      int'(slots) == fifo_depth - model_count)
    else report_mismatch("slots", fifo_depth - $sampled(model_count),
                         int'($sampled(slots)));
  a_full: assert property (@(posedge clk) disable iff (!rst_n)
      full == (model_count == fifo_depth))
    else report_mismatch("full", int'($sampled(model_count) == fifo_depth),
                         int'($sampled(full)));
  a_empty: assert property (@(posedge clk) disable iff (!rst_n)
      empty == (model_count == 0))
    else report_mismatch("empty", int'($sampled(model_count) == 0), int'($sampled(empty)));

  //--------------------------------------------------------------------------
  // Phases
  //--------------------------------------------------------------------------

  task automatic run_phases();
    // Initial grant with no pops, so every pushed word lands in the RAM
    push_enable = 1'b1;
    wait_for_credits(fifo_depth);
    if (timeout_count != 0) return;
    wait_for_occupancy(fifo_depth, "a full FIFO after the initial grant");
    if (timeout_count != 0) return;
    run_cycles(20);
    // The receiver turns random, first without and then with a held stall
    ready_mode = mode_random;
    run_cycles(200);
    stall_mode = mode_high;
    run_cycles(100);
    // Back-pressure until full again while credits trickle in
    ready_mode = mode_low;
    stall_mode = mode_random;
    wait_for_occupancy(fifo_depth, "a full FIFO under a random stall");
    if (timeout_count != 0) return;
    ready_mode = mode_random;
    run_cycles(400);
    // Always ready, so the queue empties and pushes go through the bypass
    ready_mode = mode_high;
    stall_mode = mode_low;
    run_cycles(100);
    push_enable = 1'b0;
    run_cycles(2);
    wait_for_occupancy(0, "the FIFO to drain");
    run_cycles(5);
  endtask

  initial begin
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    run_phases();
    $display("Credits %0d, pushes %0d, pops %0d", credits_rcvd, pushes_done, pops_done);
    $display("Run complete: %0d check errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_fifo_push_credit_1r1w

`default_nettype wire

// ==== all.f ====
fifo_geom_pkg.sv
credit_pkg.sv
fifo_ram_1r1w.sv
fifo_push_ctrl_credit.sv
fifo_pop_ctrl.sv
fifo_push_credit_1r1w.sv
tb_fifo_push_credit_1r1w.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the credit FIFO testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_fifo_push_credit_1r1w \
  -f all.f \
  -o sim_fifo

./obj_dir/sim_fifo | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
